//--- compile.f
cmt_pkg.sv
gpr_file.sv
csr_file.sv
cmt_unit.sv
cmt_top.sv
cmt_assert.sv
tb_cmt.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cmt
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_cmt.sv
/* commit stage testbench */

module tb_cmt;
  timeunit 1ns;
  timeprecision 1ps;

  logic                 clk;
  logic                 rst;
  cmt_pkg::wb_req_t     i_wb;
  cmt_pkg::cmt_rec_t    o_commit;
  cmt_pkg::trap_rec_t   o_trap;
  cmt_pkg::csr_state_t  o_csr;

  logic [31:0] lfsr;
  int          n;

  // reference model state
  logic [63:0]       m_regs [32];
  logic [63:0]       m_csr [6];   // indexed by csr_idx_e
  logic [63:0]       m_cycle;
  logic [63:0]       m_instr;
  logic              m_halt;
  logic [2:0]        m_code;
  logic [63:0]       m_halt_pc;
  cmt_pkg::cmt_rec_t m_commit;

  cmt_top #(
    .CNT_W (cmt_pkg::CNT_W_DEF)
  ) uut (
    .clk      (clk),
    .rst      (rst),
    .i_wb     (i_wb),
    .o_commit (o_commit),
    .o_trap   (o_trap),
    .o_csr    (o_csr)
  );

  always #5 clk = ~clk;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] rand_bits(input int nbits);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic cmt_pkg::wb_req_t gen_record(input logic allow_halt);
    cmt_pkg::wb_req_t r;
    logic [2:0]       k;
    r.valid    = (rand_bits(2) != 0);        // mostly valid
    r.skip     = (rand_bits(1) != 0);
    r.pc       = rand_bits(64);
    r.inst     = 32'(rand_bits(32));
    if (r.inst[6:0] == cmt_pkg::TRAP_OPCODE) begin
      r.inst[0] = 1'b0;
    end
    if (allow_halt && (rand_bits(6) == 0)) begin
      r.inst[6:0] = cmt_pkg::TRAP_OPCODE;
    end
    r.rd       = (rand_bits(2) == 0) ? cmt_pkg::REG_A0 : 5'(rand_bits(5));
    r.rd_wen   = (rand_bits(1) != 0);
    r.rd_wdata = rand_bits(64);
    r.intr_no  = (rand_bits(3) == 0) ? (32'(rand_bits(32)) | 32'h1) : 32'h0;
    r.csr_op   = cmt_pkg::csr_op_e'(2'(rand_bits(2)));
    k          = 3'(rand_bits(3));
    if (k > 3'd5) begin
      k = k - 3'd6;
    end
    r.csr_idx   = cmt_pkg::csr_idx_e'(k);
    r.csr_wdata = rand_bits(64);
    return r;
  endfunction

  function automatic cmt_pkg::wb_req_t make_rec(input logic [4:0] rd, input logic [63:0] wdata,
                                                input logic [31:0] intr, input logic [31:0] inst);
    cmt_pkg::wb_req_t r;
    r          = '0;
    r.valid    = 1'b1;
    r.pc       = 64'h8000_1000 + {59'd0, rd};
    r.inst     = inst;
    r.rd       = rd;
    r.rd_wen   = 1'b1;
    r.rd_wdata = wdata;
    r.intr_no  = intr;
    r.csr_op   = cmt_pkg::CSR_NONE;
    return r;
  endfunction

  task automatic model_reset();
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    for (int i = 0; i < 6; i++) begin
      m_csr[i] = '0;
    end
    m_cycle   = '0;
    m_instr   = '0;
    m_halt    = 1'b0;
    m_code    = '0;
    m_halt_pc = '0;
    m_commit  = '0;
  endtask

  task automatic model_update(input cmt_pkg::wb_req_t rec);
    logic commit_ok;
    int   idx;
    commit_ok = rec.valid && (rec.intr_no == 32'd0);
    idx       = int'(rec.csr_idx);
    if (!m_halt) begin
      m_commit.valid = commit_ok;
      m_commit.skip  = rec.skip;
      m_commit.pc    = rec.pc;
      m_commit.inst  = rec.inst;
      m_commit.wen   = rec.rd_wen;
      m_commit.wdest = {3'b000, rec.rd};
      m_commit.wdata = rec.rd_wdata;
      m_cycle = m_cycle + 64'd1;
      if (rec.valid) begin
        m_instr = m_instr + 64'd1;   // interrupted records count too
      end
      if (rec.valid && (rec.inst[6:0] == cmt_pkg::TRAP_OPCODE)) begin
        m_halt    = 1'b1;
        m_code    = m_regs[10][2:0];   // a0 before this record writes
        m_halt_pc = rec.pc;
      end
      if (commit_ok && rec.rd_wen && (rec.rd != 5'd0)) begin
        m_regs[rec.rd] = rec.rd_wdata;
      end
      if (commit_ok) begin
        case (rec.csr_op)
          cmt_pkg::CSR_WRITE: m_csr[idx] = rec.csr_wdata;
          cmt_pkg::CSR_SET:   m_csr[idx] = m_csr[idx] | rec.csr_wdata;
          cmt_pkg::CSR_CLEAR: m_csr[idx] = m_csr[idx] & ~rec.csr_wdata;
          default: ;
        endcase
      end
    end
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      $display("Simulation FAILED");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic check_outputs();
    check_val("o_commit.valid", o_commit.valid, m_commit.valid);
    check_val("o_commit.skip", o_commit.skip, m_commit.skip);
    check_val("o_commit.pc", o_commit.pc, m_commit.pc);
    check_val("o_commit.inst", o_commit.inst, m_commit.inst);
    check_val("o_commit.wen", o_commit.wen, m_commit.wen);
    check_val("o_commit.wdest", o_commit.wdest, m_commit.wdest);
    check_val("o_commit.wdata", o_commit.wdata, m_commit.wdata);
    check_val("o_trap.valid", o_trap.valid, m_halt);
    check_val("o_trap.code", o_trap.code, m_code);
    check_val("o_trap.cycle_cnt", o_trap.cycle_cnt, m_cycle);
    check_val("o_trap.instr_cnt", o_trap.instr_cnt, m_instr);
    if (m_halt) begin
      check_val("o_trap.pc", o_trap.pc, m_halt_pc);
    end
    check_val("o_csr.mstatus", o_csr.mstatus, m_csr[0]);
    check_val("o_csr.sstatus", o_csr.sstatus, m_csr[0] & cmt_pkg::SSTATUS_MASK);
    check_val("o_csr.mepc", o_csr.mepc, m_csr[1]);
    check_val("o_csr.mtvec", o_csr.mtvec, m_csr[2]);
    check_val("o_csr.mcause", o_csr.mcause, m_csr[3]);
    check_val("o_csr.mie", o_csr.mie, m_csr[4]);
    check_val("o_csr.mscratch", o_csr.mscratch, m_csr[5]);
  endtask

  // enters and leaves on a falling edge
  task automatic step(input cmt_pkg::wb_req_t rec);
    i_wb = rec;
    @(posedge clk);
    model_update(rec);
    #1;
    check_outputs();
    @(negedge clk);
  endtask

  task automatic do_reset();
    @(negedge clk);
    rst  = 1'b1;
    i_wb = '0;
    repeat (3) @(posedge clk);
    #1;
    model_reset();
    check_outputs();   // everything cleared
    check_val("o_trap.pc", o_trap.pc, 64'h0);
    @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic wait_halt(input int limit);
    int cnt;
    cnt = 0;
    while (!o_trap.valid && (cnt < limit)) begin
      step(gen_record(1'b0));
      cnt++;
    end
    if (!o_trap.valid) begin
      $display("ERROR: halt was not reported within %0d cycles", limit);
      $display("Simulation FAILED");
      $fatal(1, "halt timeout");
    end
  endtask

  task automatic force_halt(input logic [4:0] rd, input logic [63:0] wdata);
    step(make_rec(rd, wdata, 32'h0, {25'h0, cmt_pkg::TRAP_OPCODE}));
    wait_halt(10);
  endtask

  initial begin
    clk  = 1'b0;
    rst  = 1'b1;
    i_wb = '0;
    lfsr = 32'hdf3b;
    model_reset();

    // random run, halt allowed after 400 records
    do_reset();
    n = 0;
    while (!o_trap.valid && (n < 2000)) begin
      step(gen_record(n >= 400));
      n++;
    end
    if (!o_trap.valid) begin
      $display("no random halt after %0d records, forcing one", n);
      force_halt(5'(rand_bits(5)), rand_bits(64));
    end
    $display("halt after %0d records, code %0d", n, o_trap.code);
    repeat (20) step(gen_record(1'b1));   // frozen under random input
    check_val("o_trap.valid", o_trap.valid, 1'b1);

    // directed a0 and x0 writes, then halt writing a0
    do_reset();
    repeat (50) step(gen_record(1'b0));
    step(make_rec(cmt_pkg::REG_A0, 64'h1234_5678_9abc_def5, 32'h0, 32'h0000_0013));
    step(make_rec(5'd0, 64'hffff_ffff_ffff_ffff, 32'h0, 32'h0000_0013));
    step(make_rec(cmt_pkg::REG_A0, 64'h2, 32'h7, 32'h0000_0013));   // dropped by interrupt
    force_halt(cmt_pkg::REG_A0, 64'h6);
    check_val("o_trap.code", o_trap.code, 64'h5);
    repeat (20) step(gen_record(1'b1));

    // reset out of halt
    do_reset();
    repeat (20) step(gen_record(1'b0));

    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- cmt_assert.sv
/* commit stage assertions */

module cmt_assert (
  input logic                clk,
  input logic                rst,
  input cmt_pkg::run_state_e i_state,
  input cmt_pkg::wb_req_t    i_wb,
  input cmt_pkg::trap_rec_t  i_trap,
  input logic                i_gpr_wen,
  input logic                i_csr_wen
);
  timeunit 1ns;
  timeprecision 1ps;

  // halt is sticky until reset
  trap_sticky: assert property (@(posedge clk) disable iff (rst)
    i_trap.valid |=> i_trap.valid)
    else $error("trap valid fell without reset");

  no_write_halted: assert property (@(posedge clk) disable iff (rst)
    (i_state == cmt_pkg::ST_HALT) |-> (!i_gpr_wen && !i_csr_wen))
    else $error("register or csr write while halted");

  gpr_wen_no_intr: assert property (@(posedge clk) disable iff (rst)
    i_gpr_wen |-> (i_wb.intr_no == 32'd0))
    else $error("register write during an interrupt");

  cnt_frozen: assert property (@(posedge clk) disable iff (rst)
    (i_state == cmt_pkg::ST_HALT) |=>
      ($stable(i_trap.cycle_cnt) && $stable(i_trap.instr_cnt)))
    else $error("counters moved while halted");

endmodule

bind cmt_unit cmt_assert u_assert (
  .clk       (clk),
  .rst       (rst),
  .i_state   (state),
  .i_wb      (i_wb),
  .i_trap    (o_trap),
  .i_gpr_wen (o_gpr_wen),
  .i_csr_wen (o_csr_wen)
);

//--- cmt_top.sv
/* retire end top level */

module cmt_top #(
  parameter int CNT_W = 64
) (
  input  logic                clk,
  input  logic                rst,
  input  cmt_pkg::wb_req_t    i_wb,
  output cmt_pkg::cmt_rec_t   o_commit,
  output cmt_pkg::trap_rec_t  o_trap,
  output cmt_pkg::csr_state_t o_csr
);

  logic                     gpr_wen;
  logic [4:0]               gpr_waddr;
  logic [cmt_pkg::XLEN-1:0] gpr_wdata;
  logic [cmt_pkg::XLEN-1:0] a0;

  logic                     csr_wen;
  cmt_pkg::csr_op_e         csr_op;
  cmt_pkg::csr_idx_e        csr_idx;
  logic [cmt_pkg::XLEN-1:0] csr_wdata;

  cmt_unit #(
    .CNT_W (CNT_W)
  ) u_cmt (
    .clk         (clk),
    .rst         (rst),
    .i_wb        (i_wb),
    .i_a0        (a0),
    .o_gpr_wen   (gpr_wen),
    .o_gpr_waddr (gpr_waddr),
    .o_gpr_wdata (gpr_wdata),
    .o_csr_wen   (csr_wen),
    .o_csr_op    (csr_op),
    .o_csr_idx   (csr_idx),
    .o_csr_wdata (csr_wdata),
    .o_commit    (o_commit),
    .o_trap      (o_trap)
  );

  gpr_file u_gpr (
    .clk     (clk),
    .rst     (rst),
    .i_wen   (gpr_wen),
    .i_waddr (gpr_waddr),
    .i_wdata (gpr_wdata),
    .o_a0    (a0)
  );

  csr_file u_csr (
    .clk     (clk),
    .rst     (rst),
    .i_wen   (csr_wen),
    .i_op    (csr_op),
    .i_idx   (csr_idx),
    .i_wdata (csr_wdata),
    .o_csr   (o_csr)
  );

endmodule

//--- cmt_unit.sv
/* commit stage with halt detection */

module cmt_unit #(
  parameter int CNT_W = 64
) (
  input  logic                     clk,
  input  logic                     rst,
  input  cmt_pkg::wb_req_t         i_wb,
  input  logic [cmt_pkg::XLEN-1:0] i_a0,
  output logic                     o_gpr_wen,
  output logic [4:0]               o_gpr_waddr,
  output logic [cmt_pkg::XLEN-1:0] o_gpr_wdata,
  output logic                     o_csr_wen,
  output cmt_pkg::csr_op_e         o_csr_op,
  output cmt_pkg::csr_idx_e        o_csr_idx,
  output logic [cmt_pkg::XLEN-1:0] o_csr_wdata,
  output cmt_pkg::cmt_rec_t        o_commit,
  output cmt_pkg::trap_rec_t       o_trap
);

  localparam int TW = cmt_pkg::CNT_W_DEF;

  cmt_pkg::run_state_e state;

  logic [CNT_W-1:0] cycle_cnt;
  logic [CNT_W-1:0] instr_cnt;
  logic [2:0]       trap_code;

  logic running;
  logic no_intr;
  logic is_halt;

  assign running = (state == cmt_pkg::ST_RUN);
  assign no_intr = (i_wb.intr_no == 32'd0);
  assign is_halt = i_wb.valid && (i_wb.inst[6:0] == cmt_pkg::TRAP_OPCODE);

  // architectural writes only while running and not interrupted
  assign o_gpr_wen   = running && no_intr && i_wb.valid && i_wb.rd_wen;
  assign o_gpr_waddr = i_wb.rd;
  assign o_gpr_wdata = i_wb.rd_wdata;

  assign o_csr_wen   = running && no_intr && i_wb.valid &&
                       (i_wb.csr_op != cmt_pkg::CSR_NONE);
  assign o_csr_op    = i_wb.csr_op;
  assign o_csr_idx   = i_wb.csr_idx;
  assign o_csr_wdata = i_wb.csr_wdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= cmt_pkg::ST_RUN;
      o_commit  <= '0;
      cycle_cnt <= '0;
      instr_cnt <= '0;
      trap_code <= '0;
    end else if (running) begin
      o_commit.valid <= i_wb.valid && no_intr;
      o_commit.skip  <= i_wb.skip;
      o_commit.pc    <= i_wb.pc;
      o_commit.inst  <= i_wb.inst;
      o_commit.wen   <= i_wb.rd_wen;
      o_commit.wdest <= {3'b000, i_wb.rd};
      o_commit.wdata <= i_wb.rd_wdata;

      cycle_cnt <= cycle_cnt + 1'b1;
      instr_cnt <= instr_cnt + CNT_W'(i_wb.valid);  // interrupts still count

      if (is_halt) begin
        state     <= cmt_pkg::ST_HALT;
        trap_code <= i_a0[2:0];   // a0 before this record's write
      end
    end
  end

  // everything above is frozen once halted
  assign o_trap.valid     = (state == cmt_pkg::ST_HALT);
  assign o_trap.code      = trap_code;
  assign o_trap.pc        = o_commit.pc;   // pc of the halt record
  assign o_trap.cycle_cnt = TW'(cycle_cnt);
  assign o_trap.instr_cnt = TW'(instr_cnt);

endmodule

//--- csr_file.sv
/* machine CSR subset */

module csr_file (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_wen,
  input  cmt_pkg::csr_op_e         i_op,
  input  cmt_pkg::csr_idx_e        i_idx,
  input  logic [cmt_pkg::XLEN-1:0] i_wdata,
  output cmt_pkg::csr_state_t      o_csr
);

  logic [cmt_pkg::XLEN-1:0] mstatus;
  logic [cmt_pkg::XLEN-1:0] mepc;
  logic [cmt_pkg::XLEN-1:0] mtvec;
  logic [cmt_pkg::XLEN-1:0] mcause;
  logic [cmt_pkg::XLEN-1:0] mie;
  logic [cmt_pkg::XLEN-1:0] mscratch;

  logic [cmt_pkg::XLEN-1:0] cur_val;
  logic [cmt_pkg::XLEN-1:0] nxt_val;

  // read the selected csr
  always_comb begin
    case (i_idx)
      cmt_pkg::CSR_MSTATUS:  cur_val = mstatus;
      cmt_pkg::CSR_MEPC:     cur_val = mepc;
      cmt_pkg::CSR_MTVEC:    cur_val = mtvec;
      cmt_pkg::CSR_MCAUSE:   cur_val = mcause;
      cmt_pkg::CSR_MIE:      cur_val = mie;
      cmt_pkg::CSR_MSCRATCH: cur_val = mscratch;
      default:               cur_val = '0;
    endcase
  end

  always_comb begin
    case (i_op)
      cmt_pkg::CSR_WRITE: nxt_val = i_wdata;
      cmt_pkg::CSR_SET:   nxt_val = cur_val | i_wdata;
      cmt_pkg::CSR_CLEAR: nxt_val = cur_val & ~i_wdata;
      default:            nxt_val = cur_val;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus  <= '0;
      mepc     <= '0;
      mtvec    <= '0;
      mcause   <= '0;
      mie      <= '0;
      mscratch <= '0;
    end else if (i_wen) begin
      case (i_idx)
        cmt_pkg::CSR_MSTATUS:  mstatus  <= nxt_val;
        cmt_pkg::CSR_MEPC:     mepc     <= nxt_val;
        cmt_pkg::CSR_MTVEC:    mtvec    <= nxt_val;
        cmt_pkg::CSR_MCAUSE:   mcause   <= nxt_val;
        cmt_pkg::CSR_MIE:      mie      <= nxt_val;
        cmt_pkg::CSR_MSCRATCH: mscratch <= nxt_val;
        default: ;
      endcase
    end
  end

  assign o_csr.mstatus  = mstatus;
  assign o_csr.sstatus  = mstatus & cmt_pkg::SSTATUS_MASK;  // supervisor view
  assign o_csr.mepc     = mepc;
  assign o_csr.mtvec    = mtvec;
  assign o_csr.mcause   = mcause;
  assign o_csr.mie      = mie;
  assign o_csr.mscratch = mscratch;

endmodule

//--- gpr_file.sv
/* integer register file */

module gpr_file (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_wen,
  input  logic [4:0]               i_waddr,
  input  logic [cmt_pkg::XLEN-1:0] i_wdata,
  output logic [cmt_pkg::XLEN-1:0] o_a0
);

  logic [cmt_pkg::XLEN-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != 5'd0)) begin  // x0 stays zero
      regs[i_waddr] <= i_wdata;
    end
  end

  // exit code source, no clock edge
  assign o_a0 = regs[cmt_pkg::REG_A0];

endmodule

//--- cmt_pkg.sv
/* commit stage types */

package cmt_pkg;

  parameter int XLEN      = 64;
  parameter int CNT_W_DEF = 64;

  parameter logic [6:0]      TRAP_OPCODE  = 7'h6b;           // custom halt
  parameter logic [XLEN-1:0] SSTATUS_MASK = 64'h80000003_000DE122;
  parameter logic [4:0]      REG_A0       = 5'd10;

  typedef enum logic [1:0] {
    CSR_NONE,
    CSR_WRITE,
    CSR_SET,
    CSR_CLEAR
  } csr_op_e;

  typedef enum logic [2:0] {
    CSR_MSTATUS,
    CSR_MEPC,
    CSR_MTVEC,
    CSR_MCAUSE,
    CSR_MIE,
    CSR_MSCRATCH
  } csr_idx_e;

  typedef enum logic {
    ST_RUN,
    ST_HALT
  } run_state_e;

  // one write-back record per cycle
  typedef struct packed {
    logic            valid;
    logic            skip;
    logic [XLEN-1:0] pc;
    logic [31:0]     inst;
    logic [4:0]      rd;
    logic            rd_wen;
    logic [XLEN-1:0] rd_wdata;
    logic [31:0]     intr_no;     // nonzero when an interrupt is taken
    csr_op_e         csr_op;
    csr_idx_e        csr_idx;
    logic [XLEN-1:0] csr_wdata;
  } wb_req_t;

  typedef struct packed {
    logic            valid;
    logic            skip;
    logic [XLEN-1:0] pc;
    logic [31:0]     inst;
    logic            wen;
    logic [7:0]      wdest;
    logic [XLEN-1:0] wdata;
  } cmt_rec_t;

  typedef struct packed {
    logic                 valid;
    logic [2:0]           code;   // a0 at the halt
    logic [XLEN-1:0]      pc;
    logic [CNT_W_DEF-1:0] cycle_cnt;
    logic [CNT_W_DEF-1:0] instr_cnt;
  } trap_rec_t;

  typedef struct packed {
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] sstatus;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mscratch;
  } csr_state_t;

endpackage
